/* hdl/heapPkg.sv */
//----------------------------------------
// Widths are fixed here for the whole heap
// Four arrays of eight 16 bit elements
//----------------------------------------
package heapPkg;

  //----------------------------------------
  // Sizes
  //----------------------------------------
  localparam int arrayBits   = 2;                   // Bits in an array number
  localparam int indexBits   = 3;                   // Bits in an element index
  localparam int dataBits    = 16;                  // Bits in an element
  localparam int arrayCount  = 1 << arrayBits;      // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;      // Elements per array

  typedef logic [arrayBits-1:0] arrayNumT;          // Array number
  typedef logic [indexBits-1:0] indexT;             // Element index
  typedef logic [dataBits-1:0]  dataT;              // Element or response value
  typedef logic [indexBits:0]   sizeT;              // Holds zero up to arrayLength

  //----------------------------------------
  // Command and status encodings
  //----------------------------------------
  typedef enum logic [4:0] {
    opAlloc = 5'd0,                                 // Take an array, returns its number
    opFree  = 5'd1,                                 // Give an array back
    opWrite = 5'd2,                                 // Store, may grow the array
    opRead  = 5'd3,
    opSize  = 5'd4,                                 // Current length
    opPush  = 5'd5,
    opPop   = 5'd6,
    opAdd   = 5'd7,                                 // Updates return the new value
    opSub   = 5'd8,
    opAnd   = 5'd9,
    opOr    = 5'd10,
    opXor   = 5'd11
  } opT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                         // Array never taken or already freed
    errOutOfBounds  = 3'd2,                         // Index at or past the size
    errFull         = 3'd3,                         // Push with arrayLength elements
    errEmpty        = 3'd4,                         // Pop with no elements
    errOutOfMemory  = 3'd5                          // No array left to allocate
  } errorT;

  // What the element stage does with a command
  typedef enum logic [2:0] {
    elemNone   = 3'd0,                              // Nothing, response data is zero
    elemWrite  = 3'd1,                              // Store bData and return it
    elemRead   = 3'd2,                              // Return the stored element
    elemUpdate = 3'd3,                              // Combine, store and return
    elemReturn = 3'd4                               // Return bData as it is
  } elemOpT;

endpackage

/* hdl/heapAllocStage.sv */
//----------------------------------------
// Stage 1. Allocation table and free stack
// Freed arrays are reused last in, first out
// Double free is caught as errNotAllocated
//----------------------------------------
`timescale 1ns/1ns
module heapAllocStage (
  input  logic              clock,
  input  logic              reset,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  heapPkg::opT       cmdOp,
  input  heapPkg::arrayNumT cmdArray,
  input  heapPkg::indexT    cmdIndex,
  input  heapPkg::dataT     cmdData,
  output logic              aValid,
  input  logic              aReady,
  output heapPkg::opT       aOp,
  output heapPkg::arrayNumT aArray,
  output heapPkg::indexT    aIndex,
  output heapPkg::dataT     aData,
  output heapPkg::errorT    aError
);

  typedef logic [heapPkg::arrayBits:0] countT;      // Zero up to arrayCount
  localparam countT countFull = countT'(heapPkg::arrayCount);

  logic              allocated [heapPkg::arrayCount]; // One flag per array
  heapPkg::arrayNumT freeStack [heapPkg::arrayCount]; // Freed array numbers
  countT             freeTop;                       // Entries on the free stack
  countT             nextUnused;                    // First array never handed out

  logic              accept;
  logic              commandOk;                     // Accepted without error
  logic              pushFree;
  heapPkg::arrayNumT stackTop;
  heapPkg::arrayNumT chosenArray;                   // Array that goes downstream
  heapPkg::errorT    errorNext;

  assign cmdReady  = !aValid || aReady;             // Output register empty or draining
  assign accept    = cmdValid && cmdReady;
  assign commandOk = accept && errorNext == heapPkg::errNone;
  assign pushFree  = commandOk && cmdOp == heapPkg::opFree;
  assign stackTop  = heapPkg::arrayNumT'(freeTop - 1'b1);

  //----------------------------------------
  // Allocation check
  //----------------------------------------
  always_comb begin
    chosenArray = cmdArray;
    errorNext   = heapPkg::errNone;
    if (cmdOp == heapPkg::opAlloc) begin
      if (freeTop != '0) begin
        chosenArray = freeStack[stackTop];          // Reuse most recently freed
      end else if (nextUnused != countFull) begin
        chosenArray = nextUnused[heapPkg::arrayBits-1:0];
      end else begin
        errorNext = heapPkg::errOutOfMemory;
      end
    end else if (!allocated[cmdArray]) begin
      errorNext = heapPkg::errNotAllocated;         // Every other op needs a live array
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) begin
        allocated[i] <= 1'b0;
      end
      freeTop    <= '0;
      nextUnused <= '0;
    end else if (commandOk) begin
      if (cmdOp == heapPkg::opAlloc) begin
        allocated[chosenArray] <= 1'b1;
        if (freeTop != '0) begin
          freeTop <= freeTop - 1'b1;                // Pop the free stack
        end else begin
          nextUnused <= nextUnused + 1'b1;
        end
      end else if (cmdOp == heapPkg::opFree) begin
        allocated[cmdArray] <= 1'b0;                // The freed array itself
        freeTop             <= freeTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pushFree) begin
      freeStack[freeTop[heapPkg::arrayBits-1:0]] <= cmdArray;
    end
  end

  //----------------------------------------
  // Output register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      aValid <= 1'b0;
    end else if (cmdReady) begin
      aValid <= cmdValid;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      aOp    <= cmdOp;
      aArray <= chosenArray;                        // Alloc result rides here
      aIndex <= cmdIndex;
      aData  <= cmdData;
      aError <= errorNext;
    end
  end

  // Only live arrays are pushed, so the stack cannot overflow
  assert property (@(posedge clock) disable iff (!reset)
    pushFree |-> freeTop < countFull)
    else $error("free stack push while full");

endmodule

/* hdl/heapSizeStage.sv */
//----------------------------------------
// Stage 2. Array sizes and bounds checks
// Commands with an error pass through
//----------------------------------------
`timescale 1ns/1ns
module heapSizeStage (
  input  logic               clock,
  input  logic               reset,
  input  logic               aValid,
  output logic               aReady,
  input  heapPkg::opT        aOp,
  input  heapPkg::arrayNumT  aArray,
  input  heapPkg::indexT     aIndex,
  input  heapPkg::dataT      aData,
  input  heapPkg::errorT     aError,
  output logic               bValid,
  input  logic               bReady,
  output heapPkg::elemOpT    bElemOp,
  output heapPkg::opT        bOp,
  output heapPkg::arrayNumT  bArray,
  output heapPkg::indexT     bIndex,
  output heapPkg::dataT      bData,
  output heapPkg::errorT     bError
);

  localparam heapPkg::sizeT sizeFull = heapPkg::sizeT'(heapPkg::arrayLength);

  heapPkg::sizeT   sizes [heapPkg::arrayCount];     // Current length per array

  logic            accept;
  logic            sizeWrite;                       // Command changes the size
  heapPkg::sizeT   curSize;
  heapPkg::sizeT   newSize;
  heapPkg::elemOpT elemNext;
  heapPkg::indexT  indexNext;
  heapPkg::dataT   dataNext;
  heapPkg::errorT  errorNext;

  assign aReady  = !bValid || bReady;
  assign accept  = aValid && aReady;
  assign curSize = sizes[aArray];

  //----------------------------------------
  // Size checks and slot selection
  //----------------------------------------
  always_comb begin
    elemNext  = heapPkg::elemNone;
    indexNext = aIndex;
    dataNext  = aData;
    errorNext = aError;                             // Earlier error wins
    newSize   = curSize;
    sizeWrite = 1'b0;
    if (aError == heapPkg::errNone) begin
      case (aOp)
        heapPkg::opAlloc: begin
          elemNext  = heapPkg::elemReturn;
          dataNext  = heapPkg::dataT'(aArray);      // New array number
          newSize   = '0;
          sizeWrite = 1'b1;
        end
        heapPkg::opFree: begin
          elemNext = heapPkg::elemReturn;
          dataNext = '0;
        end
        heapPkg::opSize: begin
          elemNext = heapPkg::elemReturn;
          dataNext = heapPkg::dataT'(curSize);
        end
        heapPkg::opWrite: begin
          elemNext = heapPkg::elemWrite;
          if ({1'b0, aIndex} >= curSize) begin
            newSize   = {1'b0, aIndex} + 1'b1;      // Grow to cover the index
            sizeWrite = 1'b1;
          end
        end
        heapPkg::opPush: begin
          if (curSize == sizeFull) begin
            errorNext = heapPkg::errFull;
          end else begin
            elemNext  = heapPkg::elemWrite;
            indexNext = curSize[heapPkg::indexBits-1:0];
            newSize   = curSize + 1'b1;
            sizeWrite = 1'b1;
          end
        end
        heapPkg::opPop: begin
          if (curSize == '0) begin
            errorNext = heapPkg::errEmpty;
          end else begin
            elemNext  = heapPkg::elemRead;
            indexNext = heapPkg::indexT'(curSize - 1'b1); // Last element
            newSize   = curSize - 1'b1;
            sizeWrite = 1'b1;
          end
        end
        heapPkg::opRead, heapPkg::opAdd, heapPkg::opSub,
        heapPkg::opAnd, heapPkg::opOr, heapPkg::opXor: begin
          if ({1'b0, aIndex} >= curSize) begin
            errorNext = heapPkg::errOutOfBounds;
          end else if (aOp == heapPkg::opRead) begin
            elemNext = heapPkg::elemRead;
          end else begin
            elemNext = heapPkg::elemUpdate;
          end
        end
        default: begin
          elemNext = heapPkg::elemNone;
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (accept && sizeWrite) begin
      sizes[aArray] <= newSize;
    end
  end

  //----------------------------------------
  // Output register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      bValid <= 1'b0;
    end else if (aReady) begin
      bValid <= aValid;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      bElemOp <= elemNext;
      bOp     <= aOp;
      bArray  <= aArray;
      bIndex  <= indexNext;
      bData   <= dataNext;
      bError  <= errorNext;
    end
  end

  for (genvar g = 0; g < heapPkg::arrayCount; g++) begin : sizeCheck
    // Bounds depend on this holding for every array
    assert property (@(posedge clock) disable iff (!reset)
      sizes[g] <= sizeFull)
      else $error("array %0d size past arrayLength", g);
  end

endmodule

/* hdl/heapElementStage.sv */
//----------------------------------------
// Stage 3. Element storage and response
// Response data is zero on any error
//----------------------------------------
`timescale 1ns/1ns
module heapElementStage (
  input  logic              clock,
  input  logic              reset,
  input  logic              bValid,
  output logic              bReady,
  input  heapPkg::elemOpT   bElemOp,
  input  heapPkg::opT       bOp,
  input  heapPkg::arrayNumT bArray,
  input  heapPkg::indexT    bIndex,
  input  heapPkg::dataT     bData,
  input  heapPkg::errorT    bError,
  output logic              rspValid,
  input  logic              rspReady,
  output heapPkg::dataT     rspData,
  output heapPkg::errorT    rspError
);

  heapPkg::dataT elements [heapPkg::arrayCount][heapPkg::arrayLength];

  logic          accept;
  logic          storeEnable;                       // Element is written this edge
  heapPkg::dataT stored;
  heapPkg::dataT updated;
  heapPkg::dataT result;

  assign bReady = !rspValid || rspReady;
  assign accept = bValid && bReady;
  assign stored = elements[bArray][bIndex];

  //----------------------------------------
  // Element operation
  //----------------------------------------
  always_comb begin
    case (bOp)
      heapPkg::opAdd: updated = stored + bData;
      heapPkg::opSub: updated = stored - bData;
      heapPkg::opAnd: updated = stored & bData;
      heapPkg::opOr:  updated = stored | bData;
      heapPkg::opXor: updated = stored ^ bData;
      default:        updated = stored;
    endcase
  end

  always_comb begin
    result      = '0;
    storeEnable = 1'b0;
    if (bError == heapPkg::errNone) begin
      case (bElemOp)
        heapPkg::elemWrite: begin
          result      = bData;
          storeEnable = accept;
        end
        heapPkg::elemRead:   result = stored;
        heapPkg::elemUpdate: begin
          result      = updated;                    // New value goes back
          storeEnable = accept;
        end
        heapPkg::elemReturn: result = bData;
        default:             result = '0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (storeEnable) begin
      elements[bArray][bIndex] <= result;           // Write data or update result
    end
  end

  //----------------------------------------
  // Response register
  //----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      rspValid <= 1'b0;
    end else if (bReady) begin
      rspValid <= bValid;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rspData  <= result;
      rspError <= bError;
    end
  end

  // A stalled response must not change under the consumer
  assert property (@(posedge clock) disable iff (!reset)
    rspValid && !rspReady |=> rspValid && $stable(rspData) && $stable(rspError))
    else $error("response changed while stalled");

endmodule

/* hdl/heapTop.sv */
//----------------------------------------
// Three stage heap of small arrays
// Latency is three cycles, one per stage
//----------------------------------------
`timescale 1ns/1ns
module heapTop (
  input  logic              clock,
  input  logic              reset,
  input  logic              cmdValid,
  output logic              cmdReady,
  input  heapPkg::opT       cmdOp,
  input  heapPkg::arrayNumT cmdArray,
  input  heapPkg::indexT    cmdIndex,
  input  heapPkg::dataT     cmdData,
  output logic              rspValid,
  input  logic              rspReady,
  output heapPkg::dataT     rspData,
  output heapPkg::errorT    rspError
);

  // Allocation stage to size stage
  logic              aValid;
  logic              aReady;
  heapPkg::opT       aOp;
  heapPkg::arrayNumT aArray;
  heapPkg::indexT    aIndex;
  heapPkg::dataT     aData;
  heapPkg::errorT    aError;

  // Size stage to element stage
  logic              bValid;
  logic              bReady;
  heapPkg::elemOpT   bElemOp;
  heapPkg::opT       bOp;
  heapPkg::arrayNumT bArray;
  heapPkg::indexT    bIndex;
  heapPkg::dataT     bData;
  heapPkg::errorT    bError;

  heapAllocStage allocStage_i (
    .clock, .reset,
    .cmdValid, .cmdReady, .cmdOp, .cmdArray, .cmdIndex, .cmdData,
    .aValid, .aReady, .aOp, .aArray, .aIndex, .aData, .aError
  );

  heapSizeStage sizeStage_i (
    .clock, .reset,
    .aValid, .aReady, .aOp, .aArray, .aIndex, .aData, .aError,
    .bValid, .bReady, .bElemOp, .bOp, .bArray, .bIndex, .bData, .bError
  );

  heapElementStage elementStage_i (
    .clock, .reset,
    .bValid, .bReady, .bElemOp, .bOp, .bArray, .bIndex, .bData, .bError,
    .rspValid, .rspReady, .rspData, .rspError
  );

endmodule

/* dv/heapTests.svh */
//----------------------------------------
// Directed tests, run in order
// Each test starts from the state the one before left
//----------------------------------------

// Arrays 0 to 3 handed out, then LIFO reuse
task automatic allocationTest();
  repeat (5) sendCommand(heapPkg::opAlloc, 2'd0, '0, '0); // Fifth runs out
  sendCommand(heapPkg::opFree, 2'd2, '0, '0);
  sendCommand(heapPkg::opFree, 2'd1, '0, '0);
  sendCommand(heapPkg::opAlloc, 2'd0, '0, '0);      // Expect 1
  sendCommand(heapPkg::opAlloc, 2'd0, '0, '0);      // Expect 2
  reportTest("allocation");
endtask

task automatic pushPopTest();
  repeat (8) sendCommand(heapPkg::opPush, 2'd0, '0, randomBits(16));
  sendCommand(heapPkg::opPush, 2'd0, '0, randomBits(16)); // Full
  sendCommand(heapPkg::opSize, 2'd0, '0, '0);
  repeat (8) sendCommand(heapPkg::opPop, 2'd0, '0, '0);
  sendCommand(heapPkg::opPop, 2'd0, '0, '0);        // Empty
  reportTest("push pop size");
endtask

// Array 0 is empty here but every slot holds a pushed value
task automatic writeReadTest();
  sendCommand(heapPkg::opWrite, 2'd0, 3'd5, randomBits(16));
  sendCommand(heapPkg::opSize, 2'd0, '0, '0);       // Grown to 6
  for (int i = 0; i < 6; i++) begin
    sendCommand(heapPkg::opRead, 2'd0, heapPkg::indexT'(i), '0);
  end
  sendCommand(heapPkg::opRead, 2'd0, 3'd6, '0);     // Out of bounds
  sendCommand(heapPkg::opRead, 2'd0, 3'd7, '0);
  reportTest("write read");
endtask

task automatic updateTest();
  heapPkg::opT    ops [5];
  heapPkg::indexT idx;
  ops = '{heapPkg::opAdd, heapPkg::opSub, heapPkg::opAnd, heapPkg::opOr, heapPkg::opXor};
  foreach (ops[i]) begin
    idx = heapPkg::indexT'(randomBits(3) % modelSize[0]); // Stay inside the size
    sendCommand(ops[i], 2'd0, idx, randomBits(16));
    sendCommand(heapPkg::opRead, 2'd0, idx, '0);    // Stored value agrees
  end
  reportTest("updates");
endtask

task automatic freedArrayTest();
  sendCommand(heapPkg::opPush, 2'd3, '0, randomBits(16)); // Size 1 before the free
  sendCommand(heapPkg::opFree, 2'd3, '0, '0);
  sendCommand(heapPkg::opRead, 2'd3, '0, '0);
  sendCommand(heapPkg::opWrite, 2'd3, 3'd1, randomBits(16));
  sendCommand(heapPkg::opPush, 2'd3, '0, randomBits(16));
  sendCommand(heapPkg::opFree, 2'd3, '0, '0);       // Second free
  sendCommand(heapPkg::opSize, 2'd0, '0, '0);       // Other arrays untouched
  sendCommand(heapPkg::opAlloc, 2'd0, '0, '0);      // Array 3 comes back
  sendCommand(heapPkg::opSize, 2'd3, '0, '0);       // Cleared by the alloc
  sendCommand(heapPkg::opAlloc, 2'd0, '0, '0);      // Stack held array 3 only once
  reportTest("freed array");
endtask

task automatic backPressureTest();
  @(negedge clock);
  rspReady = 1'b0;
  repeat (3) sendCommand(heapPkg::opPush, 2'd1, '0, randomBits(16));
  stopCommands();
  checkCount++;
  if (cmdReady !== 1'b0) begin
    $display("[FAIL] cmdReady got 0x%0h expected 0x0 with all stages full", cmdReady);
    errorCount++;
  end
  fork
    begin
      sendCommand(heapPkg::opPush, 2'd1, '0, randomBits(16)); // Waits for space
      sendCommand(heapPkg::opSize, 2'd1, '0, '0);
      stopCommands();
    end
    begin
      repeat (4) @(negedge clock);
      rspReady = 1'b1;
    end
  join
  reportTest("back pressure");
endtask

/* dv/heapTb.sv */
//----------------------------------------
// Testbench for the three stage heap
// Expected responses come from a model that runs at issue time
// Elements are not reset, so tests only read written slots
//----------------------------------------
`timescale 1ns/1ns
module heapTb;

  localparam int commandTotal    = 63;              // Commands issued over all tests
  localparam int responseLatency = 3;               // Cycles from accept to response

  logic              clock;
  logic              reset;
  logic              cmdValid;
  logic              cmdReady;
  heapPkg::opT       cmdOp;
  heapPkg::arrayNumT cmdArray;
  heapPkg::indexT    cmdIndex;
  heapPkg::dataT     cmdData;
  logic              rspValid;
  logic              rspReady;
  heapPkg::dataT     rspData;
  heapPkg::errorT    rspError;

  int errorCount = 0;
  int checkCount = 0;
  int testCount  = 0;
  int errorsAtTestStart = 0;
  logic [31:0] lfsrState = 32'hf6f5;

  // Reference model state
  logic              modelAlloc [heapPkg::arrayCount];
  heapPkg::arrayNumT freeList [$];                  // Back of the queue is the top
  int                nextUnused = 0;
  int                modelSize [heapPkg::arrayCount];
  heapPkg::dataT     modelElem [heapPkg::arrayCount][heapPkg::arrayLength];

  heapPkg::dataT     expectData [$];                // Responses still to come
  heapPkg::errorT    expectError [$];

  // Response timing
  int cycleCount    = 0;
  int lastHoldCycle = -1;                           // Last edge with rspReady low
  int acceptCycle [$];                              // Accept edge per outstanding command
  int acceptedAt;

  heapTop dut_i (
    .clock, .reset,
    .cmdValid, .cmdReady, .cmdOp, .cmdArray, .cmdIndex, .cmdData,
    .rspValid, .rspReady, .rspData, .rspError
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //----------------------------------------
  // Stimulus data and model
  //----------------------------------------
  function automatic logic [15:0] randomBits(input int count);
    logic [15:0] value;
    logic        bitOut;
    value = '0;
    for (int i = 0; i < count; i++) begin
      bitOut    = lfsrState[0];
      lfsrState = (lfsrState >> 1) ^ (bitOut ? 32'h8020_0003 : 32'h0); // Galois taps
      value     = {value[14:0], bitOut};
    end
    return value;
  endfunction

  task automatic predictResponse(input heapPkg::opT op, input heapPkg::arrayNumT arr,
                                 input heapPkg::indexT idx, input heapPkg::dataT data);
    heapPkg::dataT     expData;
    heapPkg::errorT    expErr;
    heapPkg::arrayNumT chosen;
    heapPkg::dataT     value;
    expData = '0;
    expErr  = heapPkg::errNone;
    chosen  = arr;
    if (op == heapPkg::opAlloc) begin
      if (freeList.size() != 0) begin
        chosen = freeList.pop_back();                // Last freed comes back first
      end else if (nextUnused < heapPkg::arrayCount) begin
        chosen = heapPkg::arrayNumT'(nextUnused);
        nextUnused++;
      end else begin
        expErr = heapPkg::errOutOfMemory;
      end
      if (expErr == heapPkg::errNone) begin
        modelAlloc[chosen] = 1'b1;
        modelSize[chosen]  = 0;
        expData            = heapPkg::dataT'(chosen);
      end
    end else if (modelAlloc[arr] !== 1'b1) begin
      expErr = heapPkg::errNotAllocated;
    end else begin
      case (op)
        heapPkg::opFree: begin
          modelAlloc[arr] = 1'b0;
          freeList.push_back(arr);
        end
        heapPkg::opSize: expData = heapPkg::dataT'(modelSize[arr]);
        heapPkg::opWrite: begin
          modelElem[arr][idx] = data;
          expData             = data;
          if (int'(idx) >= modelSize[arr]) begin
            modelSize[arr] = int'(idx) + 1;
          end
        end
        heapPkg::opPush: begin
          if (modelSize[arr] == heapPkg::arrayLength) begin
            expErr = heapPkg::errFull;
          end else begin
            modelElem[arr][modelSize[arr]] = data;
            modelSize[arr]++;
            expData = data;
          end
        end
        heapPkg::opPop: begin
          if (modelSize[arr] == 0) begin
            expErr = heapPkg::errEmpty;
          end else begin
            modelSize[arr]--;
            expData = modelElem[arr][modelSize[arr]];
          end
        end
        default: begin                               // Read and the updates
          if (int'(idx) >= modelSize[arr]) begin
            expErr = heapPkg::errOutOfBounds;
          end else begin
            value = modelElem[arr][idx];
            case (op)
              heapPkg::opAdd: value = value + data;
              heapPkg::opSub: value = value - data;
              heapPkg::opAnd: value = value & data;
              heapPkg::opOr:  value = value | data;
              heapPkg::opXor: value = value ^ data;
              default:        value = value;
            endcase
            if (op != heapPkg::opRead) begin
              modelElem[arr][idx] = value;
            end
            expData = value;
          end
        end
      endcase
    end
    expectData.push_back(expData);
    expectError.push_back(expErr);
  endtask

  //----------------------------------------
  // Drive and compare
  //----------------------------------------
  task automatic sendCommand(input heapPkg::opT op, input heapPkg::arrayNumT arr,
                             input heapPkg::indexT idx, input heapPkg::dataT data);
    @(negedge clock);
    cmdValid = 1'b1;
    cmdOp    = op;
    cmdArray = arr;
    cmdIndex = idx;
    cmdData  = data;
    predictResponse(op, arr, idx, data);
    do begin
      @(posedge clock);
    end while (cmdReady !== 1'b1);                  // Held until accepted
  endtask

  task automatic stopCommands();
    @(negedge clock);
    cmdValid = 1'b0;
  endtask

  task automatic compareData(input string name, input heapPkg::dataT got,
                             input heapPkg::dataT expected);
    checkCount++;
    if (got !== expected) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
      errorCount++;
    end
  endtask

  task automatic compareError(input string name, input heapPkg::errorT got,
                              input heapPkg::errorT expected);
    checkCount++;
    if (got !== expected) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
      errorCount++;
    end
  endtask

  task automatic compareLatency(input string name, input int got, input int expected);
    checkCount++;
    if (got != expected) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
      errorCount++;
    end
  endtask

  task automatic waitIdle();
    int cycles;
    stopCommands();
    cycles = 0;
    while (expectData.size() != 0 && cycles < 50) begin
      @(negedge clock);
      cycles++;
    end
    if (expectData.size() != 0) begin
      $display("%0d commands never got a response", expectData.size());
      errorCount++;
      expectData.delete();
      expectError.delete();
      acceptCycle.delete();
    end
  endtask

  task automatic reportTest(input string name);
    waitIdle();
    testCount++;
    $display("%s done, %0d errors", name, errorCount - errorsAtTestStart);
    errorsAtTestStart = errorCount;
  endtask

  // Response collector, values taken as they stand before the edge
  always @(posedge clock) begin
    if (reset === 1'b1) begin
      if (cmdValid === 1'b1 && cmdReady === 1'b1) begin
        acceptCycle.push_back(cycleCount);
      end
      if (rspValid === 1'b1 && rspReady === 1'b1) begin
        if (expectData.size() == 0) begin
          $display("response arrived with no command outstanding");
          errorCount++;
        end else begin
          compareError("rspError", rspError, expectError.pop_front());
          compareData("rspData", rspData, expectData.pop_front());
          acceptedAt = acceptCycle.pop_front();
          if (acceptedAt > lastHoldCycle) begin   // No stall since it was accepted
            compareLatency("rspValid latency", cycleCount - acceptedAt, responseLatency);
          end
        end
      end
      if (rspReady !== 1'b1) begin
        lastHoldCycle = cycleCount;
      end
      cycleCount++;
    end
  end

  `include "heapTests.svh"

  //----------------------------------------
  // Main sequence and watchdog
  //----------------------------------------
  initial begin
    reset    = 1'b0;
    cmdValid = 1'b0;
    cmdOp    = heapPkg::opAlloc;
    cmdArray = '0;
    cmdIndex = '0;
    cmdData  = '0;
    rspReady = 1'b1;
    for (int i = 0; i < heapPkg::arrayCount; i++) begin
      modelAlloc[i] = 1'b0;
      modelSize[i]  = 0;
    end
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    allocationTest();
    pushPopTest();
    writeReadTest();
    updateTest();
    freedArrayTest();
    backPressureTest();
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (16 + commandTotal * 40) @(posedge clock);
    $display("timeout, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sources.f */
+incdir+dv
hdl/heapPkg.sv
hdl/heapAllocStage.sv
hdl/heapSizeStage.sv
hdl/heapElementStage.sv
hdl/heapTop.sv
dv/heapTb.sv

/* Makefile */
# Verilator build and run of the heap testbench

SIM := obj_dir/VheapTb

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(wildcard hdl/*.sv dv/*.sv dv/*.svh)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module heapTb -f sources.f

sim.log: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log

# Pass or fail decided by the log alone
run: sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
